// File: obj_stim.txt
# W entry x y code attr | L vrender flip off_y | E addr word | R test_name (numbers hex)
# E words {prio, bank, pal, pix} are read back after the next line swap
R single_tile
W 000 4040 2020 0123 0005
W 001 0000 8000 0000 0000
L 025 0 000
E 03e 000f
E 03f 000f
E 040 1252
E 046 1254
E 047 1250
E 04c 000f
E 04e 1255
E 04f 000f
R multi_tile_hflip
W 000 0064 0050 0210 1203
W 001 0000 8000 0000 0000
L 055 0 000
E 063 003b
E 064 003e
E 073 003c
E 074 000f
E 075 0032
E 083 003d
E 084 0030
W 000 0064 0050 0210 1223
L 055 0 000
E 063 003d
E 073 003c
E 083 003b
L 063 0 000
E 063 003a
E 073 0039
E 083 0038
R zone_offset_vflip
W 000 00c8 0064 0300 0002
W 001 0104 0064 0300 0081
W 002 0000 8000 0000 0000
L 06e 0 008
E 0c7 000f
E 103 0014
L 062 0 008
E 0c7 002c
E 103 000f
W 000 00c8 0064 0300 0042
L 062 0 008
E 0c7 0022
E 0c8 0025
L 09d 1 008
E 0c7 0022
E 103 000f
R end_marker_overlap
W 000 2050 0028 0400 0007
W 001 4058 0028 0405 0009
W 002 0000 8000 0000 0000
W 003 0096 0028 0400 0001
L 02c 0 000
E 04f 0878
E 057 0879
E 059 1093
E 05f 109e
E 095 000f
R clear_and_swap
W 000 00a0 0028 0400 0007
W 001 0210 0028 0400 0007
W 002 0000 8000 0000 0000
L 02c 0 000
E 09f 0078
E 00f 000f
W 000 00b0 0028 0400 0007
L 02c 0 000
E 0af 0078
E 09f 000f
L 02c 0 000
E 09f 000f
E 0af 0078

// File: tb.f
obj_pkg.sv
obj_table.sv
obj_tile_match.sv
obj_scan.sv
obj_draw.sv
obj_line_buf.sv
obj_engine.sv
tb_clk.sv
obj_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module obj_tb -f tb.f -o obj_sim

run: compile
	./obj_dir/obj_sim | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: obj_tb.sv
// object engine testbench: stim file reader, ROM model, line buffer sweep checks
`default_nettype none

module obj_tb;

    logic                clk;
    logic                rst;
    logic                tbl_we;
    obj_pkg::taddr_t     tbl_waddr;
    obj_pkg::widx_t      tbl_wsel;
    obj_pkg::word_t      tbl_wdata;
    logic                line_start;
    obj_pkg::vpos_t      vrender;
    logic                flip;
    logic [9:0]          off_y;
    logic                rom_cs;
    obj_pkg::romaddr_t   rom_addr;
    obj_pkg::romdata_t   rom_data;
    logic                rd_en;
    obj_pkg::hpos_t      rd_addr;
    obj_pkg::lbuf_t      rd_data;
    logic                line_done;

    obj_pkg::lbuf_t      exp_word [512];  // expected words for the line in the read bank
    logic                exp_valid [512];
    int                  n_pending;
    int                  test_err;
    int                  test_checks;
    int                  n_pass;
    int                  n_fail;
    logic                test_open;
    logic                timed_out;
    logic [8*32-1:0]     test_name;
    obj_pkg::vpos_t      last_vr;          // repeated by the flush line
    logic                last_fl;
    logic [9:0]          last_oy;

    tb_clk u_clk (.clk(clk));

    obj_engine #(.tbl_aw(10), .lb_aw(9)) DUT (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_waddr(tbl_waddr), .tbl_wsel(tbl_wsel),
        .tbl_wdata(tbl_wdata), .line_start(line_start), .vrender(vrender), .flip(flip),
        .off_y(off_y), .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .line_done(line_done)
    );

    // nibble k is addr + code low nibble + code next nibble + 3k with nibble 0 leftmost
    function automatic obj_pkg::romdata_t rom_word(input obj_pkg::romaddr_t a);
        obj_pkg::romdata_t w;
        logic [3:0]        base;
        w    = '0;
        base = a[3:0] + a[8:5] + a[12:9];
        for (int k = 0; k < 8; k++) begin
            w[31-4*k -: 4] = base + 4'(3 * k);
        end
        return w;
    endfunction

    // graphics ROM model one cycle behind rom_cs
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_data <= '0;
        end else if (rom_cs) begin
            rom_data <= rom_word(rom_addr);
        end
    end

    task automatic wait_done;
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!line_done && cyc < 20000) begin
            @(negedge clk);
            cyc++;
        end
        if (!line_done) begin
            $display("timeout: line_done never came back high in test %0s", test_name);
            test_err++;
            timed_out = 1'b1;
        end else begin
            assert (!rom_cs) else begin
                $display("rom_cs still active with line_done high in test %0s", test_name);
                test_err++;
            end
        end
    endtask

    task automatic write_entry(input obj_pkg::taddr_t a, input obj_pkg::word_t x,
                               input obj_pkg::word_t y, input obj_pkg::word_t c,
                               input obj_pkg::word_t at);
        obj_pkg::word_t w [4];
        w[0] = x;
        w[1] = y;
        w[2] = c;
        w[3] = at;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_waddr <= a;
            tbl_wsel  <= 2'(i);
            tbl_wdata <= w[i];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // sweep reads clear the whole bank and compare the listed addresses
    task automatic sweep_check;
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= 9'(a);
            @(posedge clk);
            rd_en <= 1'b0;
            @(negedge clk);
            if (exp_valid[a]) begin
                test_checks++;
                assert (rd_data === exp_word[a]) else begin
                    $display("FAIL %0s addr %h expected %h actual %h",
                             test_name, 9'(a), exp_word[a], rd_data);
                    test_err++;
                end
                exp_valid[a] = 1'b0;
            end
        end
        n_pending = 0;
    endtask

    task automatic run_line(input obj_pkg::vpos_t vr, input logic fl, input logic [9:0] oy);
        last_vr = vr;
        last_fl = fl;
        last_oy = oy;
        @(posedge clk);
        line_start <= 1'b1;
        vrender    <= vr;
        flip       <= fl;
        off_y      <= oy;
        @(posedge clk);
        line_start <= 1'b0;
        sweep_check();  // previous line sits in the read bank now
        wait_done();
    endtask

    task automatic close_test;
        if (n_pending > 0 && !timed_out) begin
            run_line(last_vr, last_fl, last_oy);  // extra swap brings the last line out
        end
        if (test_open || test_err > 0) begin
            if (test_err == 0) begin
                $display("PASS %0s (%0d checks)", test_name, test_checks);
                n_pass++;
            end else begin
                $display("FAIL %0s (%0d of %0d checks wrong)", test_name, test_err,
                         test_checks);
                n_fail++;
            end
        end
        test_err    = 0;
        test_checks = 0;
    endtask

    initial begin
        int              fd;
        int              r;
        logic [8*32-1:0] cmd;
        logic [8*128-1:0] junk;
        logic [15:0]     f0;
        logic [15:0]     f1;
        logic [15:0]     f2;
        logic [15:0]     f3;
        logic [15:0]     f4;
        rst        <= 1'b1;
        tbl_we     <= 1'b0;
        tbl_waddr  <= '0;
        tbl_wsel   <= '0;
        tbl_wdata  <= '0;
        line_start <= 1'b0;
        vrender    <= '0;
        flip       <= 1'b0;
        off_y      <= '0;
        rd_en      <= 1'b0;
        rd_addr    <= '0;
        for (int i = 0; i < 512; i++) begin
            exp_valid[i] = 1'b0;
            exp_word[i]  = '0;
        end
        n_pending   = 0;
        test_err    = 0;
        test_checks = 0;
        n_pass      = 0;
        n_fail      = 0;
        test_open   = 1'b0;
        timed_out   = 1'b0;
        test_name   = "startup";
        last_vr     = '0;
        last_fl     = 1'b0;
        last_oy     = '0;
        fd = $fopen("obj_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open obj_stim.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            wait_done();  // line buffer reset clear
            while (!$feof(fd) && !timed_out) begin
                r = $fscanf(fd, "%s", cmd);
                if (r != 1) break;
                if (cmd == "#") begin
                    r = $fgets(junk, fd);
                end else if (cmd == "W") begin
                    r = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    write_entry(f0[9:0], f1, f2, f3, f4);
                end else if (cmd == "L") begin
                    r = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    run_line(f0[8:0], f1[0], f2[9:0]);
                end else if (cmd == "E") begin
                    r = $fscanf(fd, "%h %h", f0, f1);
                    exp_word[f0[8:0]]  = f1;
                    exp_valid[f0[8:0]] = 1'b1;
                    n_pending++;
                end else if (cmd == "R") begin
                    close_test();
                    r = $fscanf(fd, "%s", test_name);
                    test_open = 1'b1;
                end else begin
                    $display("unknown stim command %0s in test %0s", cmd, test_name);
                    test_err++;
                end
            end
            $fclose(fd);
            close_test();
            $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
            if (n_fail == 0 && !timed_out) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb_clk.sv
// testbench clock source, 10 unit period
`default_nettype none

module tb_clk (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;  // half period
        end
    end

endmodule

`default_nettype wire

// File: obj_engine.sv
// object engine top: table, scanner, draw engine and line buffer wiring
`default_nettype none

module obj_engine #(
    parameter int tbl_aw = 10,
    parameter int lb_aw  = 9
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              tbl_we,
    input  wire obj_pkg::taddr_t  tbl_waddr,
    input  wire obj_pkg::widx_t   tbl_wsel,
    input  wire obj_pkg::word_t   tbl_wdata,
    input  wire              line_start,
    input  wire obj_pkg::vpos_t   vrender,
    input  wire              flip,
    input  wire [9:0]        off_y,
    output wire              rom_cs,
    output wire obj_pkg::romaddr_t rom_addr,
    input  wire obj_pkg::romdata_t rom_data,
    input  wire              rd_en,
    input  wire obj_pkg::hpos_t   rd_addr,
    output wire obj_pkg::lbuf_t   rd_data,
    output wire              line_done
);
    obj_pkg::taddr_t  table_addr;
    obj_pkg::word_t   table_x;
    obj_pkg::word_t   table_y;
    obj_pkg::word_t   table_code;
    obj_pkg::word_t   table_attr;
    obj_pkg::word_t   dr_code;
    obj_pkg::word_t   dr_attr;
    obj_pkg::hpos_t   dr_hpos;
    obj_pkg::prio_t   dr_prio;
    obj_pkg::bank_t   dr_bank;
    logic             dr_start;
    logic             dr_idle;
    logic             scan_busy;
    logic             lb_we;
    logic [lb_aw-1:0] lb_addr;
    obj_pkg::lbuf_t   lb_data;
    logic             lb_ready;

    // scanner finished, last tile drawn and buffer out of its reset clear
    assign line_done = ~scan_busy & dr_idle & lb_ready;

    obj_table #(.tbl_aw(tbl_aw)) u_table (
        .clk(clk), .we(tbl_we), .waddr(tbl_waddr), .wsel(tbl_wsel), .wdata(tbl_wdata),
        .raddr(table_addr), .x(table_x), .y(table_y), .code(table_code), .attr(table_attr)
    );

    obj_scan #(.tbl_aw(tbl_aw)) u_scan (
        .clk(clk), .rst(rst), .line_start(line_start), .flip(flip), .vrender(vrender),
        .off_y(off_y), .table_addr(table_addr), .table_x(table_x), .table_y(table_y),
        .table_code(table_code), .table_attr(table_attr), .dr_idle(dr_idle),
        .dr_start(dr_start), .dr_code(dr_code), .dr_attr(dr_attr), .dr_hpos(dr_hpos),
        .dr_prio(dr_prio), .dr_bank(dr_bank), .scan_busy(scan_busy)
    );

    obj_draw #(.lb_aw(lb_aw)) u_draw (
        .clk(clk), .rst(rst), .dr_start(dr_start), .dr_code(dr_code), .dr_attr(dr_attr),
        .dr_hpos(dr_hpos), .dr_prio(dr_prio), .dr_bank(dr_bank), .dr_idle(dr_idle),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data),
        .lb_we(lb_we), .lb_addr(lb_addr), .lb_data(lb_data)
    );

    obj_line_buf #(.lb_aw(lb_aw)) u_line_buf (
        .clk(clk), .rst(rst), .line_start(line_start), .lb_we(lb_we), .lb_addr(lb_addr),
        .lb_data(lb_data), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .ready(lb_ready)
    );

endmodule

`default_nettype wire

// File: obj_line_buf.sv
// double-banked line buffer with first-opaque-wins writes and clear-on-read
`default_nettype none

module obj_line_buf #(
    parameter int lb_aw = 9
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             line_start,
    input  wire             lb_we,
    input  wire [lb_aw-1:0] lb_addr,
    input  wire obj_pkg::lbuf_t  lb_data,
    input  wire             rd_en,
    input  wire obj_pkg::hpos_t  rd_addr,
    output obj_pkg::lbuf_t  rd_data,
    output logic            ready     // low while the reset clear runs
);
    obj_pkg::lbuf_t mem [2**(lb_aw+1)];  // bank select is the top address bit
    logic           sel;                 // bank being drawn
    logic [lb_aw:0] clr_cnt;
    logic           clr_busy;
    logic [lb_aw:0] wr_idx;
    logic [lb_aw:0] rd_idx;
    logic           wr_ok;

    assign wr_idx = {sel, lb_addr};
    assign rd_idx = {~sel, rd_addr[lb_aw-1:0]};
    // earlier objects keep their pixel, later ones only fill gaps
    assign wr_ok  = lb_we && (lb_data[3:0] != obj_pkg::lb_clear[3:0])
                    && (mem[wr_idx][3:0] == obj_pkg::lb_clear[3:0]);
    assign ready  = ~clr_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel      <= 1'b0;
            clr_cnt  <= '0;
            clr_busy <= 1'b1;
        end else begin
            if (line_start) sel <= ~sel;
            if (clr_busy) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (&clr_cnt) clr_busy <= 1'b0;  // both banks walked
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy) begin
            mem[clr_cnt] <= obj_pkg::lb_clear;
        end else begin
            if (wr_ok) mem[wr_idx] <= lb_data;
            if (rd_en) mem[rd_idx] <= obj_pkg::lb_clear;  // leave it clean for reuse
        end
        if (rd_en) rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

// File: obj_draw.sv
// tile draw engine: two ROM word fetch, then 16 pixel writes to the line buffer
`default_nettype none

module obj_draw #(
    parameter int lb_aw = 9
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              dr_start,
    input  wire obj_pkg::word_t   dr_code,
    input  wire obj_pkg::word_t   dr_attr,
    input  wire obj_pkg::hpos_t   dr_hpos,
    input  wire obj_pkg::prio_t   dr_prio,
    input  wire obj_pkg::bank_t   dr_bank,
    output logic             dr_idle,
    output logic             rom_cs,
    output obj_pkg::romaddr_t rom_addr,
    input  wire obj_pkg::romdata_t rom_data,
    output logic             lb_we,
    output logic [lb_aw-1:0] lb_addr,
    output obj_pkg::lbuf_t   lb_data
);
    obj_pkg::draw_st_t st;
    logic [63:0]       pix;     // current pixel in the top nibble
    obj_pkg::tilen_t   cnt;     // pixel index in the tile
    logic [lb_aw-1:0]  cur_x;
    logic [4:0]        pal;
    obj_pkg::prio_t    prio;
    obj_pkg::bank_t    bank;

    assign dr_idle = (st == obj_pkg::ds_idle);
    assign lb_we   = (st == obj_pkg::ds_write);
    assign lb_addr = cur_x;
    assign lb_data = {2'b00, prio, bank, pal, pix[63:60]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= obj_pkg::ds_idle;
            rom_cs <= 1'b0;
            cnt    <= '0;
        end else begin
            case (st)
                obj_pkg::ds_idle: if (dr_start) begin
                    st     <= obj_pkg::ds_rom0;
                    rom_cs <= 1'b1;
                end
                obj_pkg::ds_rom0: st <= obj_pkg::ds_rom1;  // second read, cs held
                obj_pkg::ds_rom1: begin
                    st     <= obj_pkg::ds_write;
                    rom_cs <= 1'b0;
                end
                default: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15 || (&cur_x)) begin  // tile done or line end
                        st  <= obj_pkg::ds_idle;
                        cnt <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            obj_pkg::ds_idle: if (dr_start) begin
                rom_addr <= {1'b0, dr_code, dr_attr[11:8], 1'b0};  // code*32 + vsub*2
                cur_x    <= dr_hpos[lb_aw-1:0];
                pal      <= dr_attr[4:0];
                prio     <= dr_prio;
                bank     <= dr_bank;
            end
            obj_pkg::ds_rom0: rom_addr[0] <= 1'b1;  // right half
            obj_pkg::ds_rom1: pix[63:32] <= rom_data;
            default: begin
                cur_x <= cur_x + 1'b1;
                // second word lands as the first pixel goes out
                pix <= (cnt == 4'd0) ? {pix[59:32], rom_data, 4'hf} : {pix[59:0], 4'hf};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: obj_scan.sv
// per-line object table walker with tile expansion and draw request issue
`default_nettype none

module obj_scan #(
    parameter int tbl_aw = 10
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             line_start,
    input  wire             flip,
    input  wire obj_pkg::vpos_t  vrender,
    input  wire [9:0]       off_y,
    output obj_pkg::taddr_t table_addr,
    input  wire obj_pkg::word_t  table_x,
    input  wire obj_pkg::word_t  table_y,
    input  wire obj_pkg::word_t  table_code,
    input  wire obj_pkg::word_t  table_attr,
    input  wire             dr_idle,
    output logic            dr_start,
    output obj_pkg::word_t  dr_code,
    output obj_pkg::word_t  dr_attr,
    output obj_pkg::hpos_t  dr_hpos,
    output obj_pkg::prio_t  dr_prio,
    output obj_pkg::bank_t  dr_bank,
    output logic            scan_busy
);
    obj_pkg::scan_st_t st;
    obj_pkg::vpos_t    vrenderf;        // line as seen by the table, flip applied
    logic [9:0]        obj_y;
    logic [9:0]        eff_x;
    obj_pkg::tilen_t   n;               // tile column for the code
    obj_pkg::tilen_t   npos;            // tile column on screen
    obj_pkg::tilen_t   tile_m;
    obj_pkg::tilen_t   tile_n;
    obj_pkg::tilen_t   vsub;
    obj_pkg::word_t    code_mn;
    logic              zone_ok;
    logic              hflip;
    logic              last_entry;
    logic              take;

    assign tile_m     = table_attr[15:12];
    assign tile_n     = table_attr[11:8];
    assign hflip      = table_attr[5];
    assign eff_x      = table_x[9:0] + {2'b00, npos, 4'h0};
    assign last_entry = (table_addr[tbl_aw-1:0] == {tbl_aw{1'b1}});
    assign scan_busy  = (st != obj_pkg::ss_idle);
    assign take       = (st == obj_pkg::ss_zone) && zone_ok && dr_idle;

    obj_tile_match u_match (
        .clk      (clk),
        .obj_code (table_code),
        .tile_m   (tile_m),
        .tile_n   (tile_n),
        .n        (n),
        .vflip    (table_attr[6]),
        .vrenderf (vrenderf),
        .obj_y    (obj_y),
        .zone_ok  (zone_ok),
        .vsub     (vsub),
        .code_mn  (code_mn)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= obj_pkg::ss_idle;
            table_addr <= '0;
            dr_start   <= 1'b0;
            vrenderf   <= '0;
            obj_y      <= '0;
            n          <= '0;
            npos       <= '0;
        end else begin
            dr_start <= 1'b0;  // single cycle pulse
            case (st)
                obj_pkg::ss_fetch: st <= obj_pkg::ss_wait_rd;  // table read in flight
                obj_pkg::ss_wait_rd: begin
                    if (table_y[15] || (&table_attr[15:8])) begin
                        st <= obj_pkg::ss_idle;  // end marker
                    end else begin
                        obj_y <= table_y[9:0] - (table_attr[7] ? 10'd0 : off_y);
                        n     <= '0;
                        npos  <= hflip ? tile_n : 4'd0;  // rightmost first under hflip
                        st    <= obj_pkg::ss_check;
                    end
                end
                obj_pkg::ss_check: st <= obj_pkg::ss_zone;  // match registers here
                obj_pkg::ss_zone: begin
                    if (!zone_ok) begin
                        table_addr <= table_addr + 1'b1;
                        st         <= last_entry ? obj_pkg::ss_idle : obj_pkg::ss_fetch;
                    end else if (dr_idle) begin
                        dr_start <= ~eff_x[9];  // off the right edge, skip
                        st       <= obj_pkg::ss_issue;
                    end
                end
                obj_pkg::ss_issue: st <= obj_pkg::ss_next_tile;  // lets dr_idle drop
                obj_pkg::ss_next_tile: begin
                    if (n == tile_n) begin
                        table_addr <= table_addr + 1'b1;
                        st         <= last_entry ? obj_pkg::ss_idle : obj_pkg::ss_fetch;
                    end else begin
                        n    <= n + 1'b1;
                        npos <= hflip ? npos - 1'b1 : npos + 1'b1;
                        st   <= obj_pkg::ss_check;
                    end
                end
                default: st <= obj_pkg::ss_idle;
            endcase
            // new line wins over anything in progress
            if (line_start) begin
                st         <= obj_pkg::ss_fetch;
                table_addr <= '0;
                vrenderf   <= vrender ^ {1'b0, {8{flip}}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dr_code <= code_mn;
            dr_attr <= {4'd0, vsub, table_attr[7:0]};
            dr_hpos <= eff_x[8:0] - 9'd1;
            dr_prio <= table_x[15:13];
            dr_bank <= table_y[14:13];
        end
    end

endmodule

`default_nettype wire

// File: obj_tile_match.sv
// vertical zone test, sub-row and per-tile code for one object tile
`default_nettype none

module obj_tile_match (
    input  wire             clk,
    input  wire obj_pkg::word_t  obj_code,
    input  wire obj_pkg::tilen_t tile_m,   // tile rows minus one
    input  wire obj_pkg::tilen_t tile_n,   // tile columns minus one
    input  wire obj_pkg::tilen_t n,        // current column
    input  wire             vflip,
    input  wire obj_pkg::vpos_t  vrenderf,
    input  wire [9:0]       obj_y,
    output logic            zone_ok,
    output obj_pkg::tilen_t vsub,
    output obj_pkg::word_t  code_mn
);
    logic [9:0]      row;      // line relative to object top
    logic            in_rows;
    obj_pkg::tilen_t m_raw;
    obj_pkg::tilen_t m_eff;

    assign row     = {1'b0, vrenderf} - obj_y;       // wraps mod 1024, negatives fail below
    assign m_raw   = row[7:4];
    assign in_rows = (row[9:8] == 2'b00) && (m_raw <= tile_m);
    assign m_eff   = vflip ? tile_m - m_raw : m_raw; // mirrored tile row

    always_ff @(posedge clk) begin
        zone_ok <= in_rows && (n <= tile_n);
        vsub    <= row[3:0] ^ {4{vflip}};
        // column adds into the low nibble only, row carries up from bit 4
        code_mn <= {obj_code[15:4] + {8'd0, m_eff}, obj_code[3:0] + n};
    end

endmodule

`default_nettype wire

// File: obj_table.sv
// object table RAM: host write port, registered four-word read port
`default_nettype none

module obj_table #(
    parameter int tbl_aw = 10
) (
    input  wire             clk,
    input  wire             we,
    input  wire obj_pkg::taddr_t waddr,
    input  wire obj_pkg::widx_t  wsel,
    input  wire obj_pkg::word_t  wdata,
    input  wire obj_pkg::taddr_t raddr,
    output obj_pkg::word_t  x,
    output obj_pkg::word_t  y,
    output obj_pkg::word_t  code,
    output obj_pkg::word_t  attr
);
    // one array per field so a whole entry comes out in one read
    obj_pkg::word_t mem_x    [2**tbl_aw];
    obj_pkg::word_t mem_y    [2**tbl_aw];
    obj_pkg::word_t mem_code [2**tbl_aw];
    obj_pkg::word_t mem_attr [2**tbl_aw];

    always_ff @(posedge clk) begin
        if (we) begin
            case (wsel)
                2'd0: mem_x[waddr[tbl_aw-1:0]] <= wdata;
                2'd1: mem_y[waddr[tbl_aw-1:0]] <= wdata;
                2'd2: mem_code[waddr[tbl_aw-1:0]] <= wdata;
                default: mem_attr[waddr[tbl_aw-1:0]] <= wdata;
            endcase
        end
        x    <= mem_x[raddr[tbl_aw-1:0]];     // valid the cycle after raddr
        y    <= mem_y[raddr[tbl_aw-1:0]];
        code <= mem_code[raddr[tbl_aw-1:0]];
        attr <= mem_attr[raddr[tbl_aw-1:0]];
    end

endmodule

`default_nettype wire

// File: obj_pkg.sv
// object engine package: field widths, vector typedefs, scanner and draw state enums
`default_nettype none

package obj_pkg;

    typedef logic [15:0] word_t;    // one table word: x, y, code or attr
    typedef logic [9:0]  taddr_t;   // object index, 1024 entries
    typedef logic [1:0]  widx_t;    // 0 x, 1 y, 2 code, 3 attr
    typedef logic [8:0]  vpos_t;    // line number
    typedef logic [8:0]  hpos_t;    // pixel column
    typedef logic [3:0]  tilen_t;   // tile count, tile index or sub-row
    typedef logic [2:0]  prio_t;
    typedef logic [1:0]  bank_t;
    typedef logic [3:0]  pix_t;     // 15 means transparent
    typedef logic [15:0] lbuf_t;    // {2'b0, prio, bank, pal[4:0], pix}
    typedef logic [21:0] romaddr_t; // 32-bit word address
    typedef logic [31:0] romdata_t; // 8 pixels, nibble 0 leftmost

    localparam lbuf_t lb_clear = 16'h000f;  // empty line buffer word

    typedef enum logic [2:0] {
        ss_idle, ss_fetch, ss_wait_rd, ss_check, ss_zone, ss_issue, ss_next_tile
    } scan_st_t;

    typedef enum logic [1:0] {ds_idle, ds_rom0, ds_rom1, ds_write} draw_st_t;

endpackage

`default_nettype wire
